// File: arb_subsys.f
hdl/arb_pkg.sv
hdl/req_if.sv
hdl/rr_state.sv
hdl/arb_pri_rr.sv
hdl/req_slot.sv
hdl/req_dispatch.sv
hdl/grant_mux.sv
hdl/arb_subsys.sv
tb/arb_subsys_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the arbitration subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arb_subsys.f --top-module arb_subsys_tb -o arb_subsys_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/arb_subsys_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: tb/arb_subsys_tb.sv
// ------------------------------------------------------------
// Arbitration subsystem testbench
// Directed tests and a random mix, checked against a model
// of the slots and the round-robin pointer
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module arb_subsys_tb;
  import arb_pkg::*;

  // Upper bounds on the run length, the timeout is twice their sum
  localparam int random_cycles = 200;
  localparam int test_cycles = 4 + 50 + random_cycles + num_req;
  localparam int timeout_cycles = 2 * test_cycles;

  logic clk;
  logic reset;
  logic in_valid;
  logic [idx_w-1:0] in_port;
  logic [pri_w-1:0] in_pri;
  logic [data_w-1:0] in_data;
  logic update_en;
  logic in_reject;
  logic [num_req-1:0] slot_full;
  logic out_valid;
  logic [idx_w-1:0] out_port;
  logic [pri_w-1:0] out_pri;
  logic [data_w-1:0] out_data;

  // Model of the slots and the last granted index
  logic [num_req-1:0] model_full;
  int model_pri [num_req];
  int model_data [num_req];
  int model_last;
  int accepted;

  // Outputs seen during the current test
  int port_log[$];
  int pri_log[$];
  int data_log[$];

  string test_name;
  int test_errors;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int cycle_count = 0;

  arb_subsys arb_subsys_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_port   (in_port),
    .in_pri    (in_pri),
    .in_data   (in_data),
    .update_en (update_en),
    .in_reject (in_reject),
    .slot_full (slot_full),
    .out_valid (out_valid),
    .out_port  (out_port),
    .out_pri   (out_pri),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= timeout_cycles);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------

  task automatic check_value(string what, int expected, int actual);
    checks++;
    assert (expected == actual) else begin
      $display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_order(string what, int expected[$], int actual[$]);
    check_value({what, " count"}, expected.size(), actual.size());
    for (int k = 0; k < expected.size() && k < actual.size(); k++) begin
      check_value($sformatf("%s %0d", what, k), expected[k], actual[k]);
    end
  endtask

  // Highest priority among full slots, ties go to the first full
  // index after the last granted one, -1 when nothing is held
  function automatic int pick_winner();
    int best;
    int idx;
    best = -1;
    for (int k = 1; k <= num_req; k++) begin
      idx = (model_last + k) % num_req;
      if (model_full[idx] && (best < 0 || model_pri[idx] > model_pri[best])) begin
        best = idx;
      end
    end
    return best;
  endfunction

  // One clock edge: predict, clock, update the model and compare.
  // Inputs stay as driven, except in_valid which is a single pulse
  task automatic clock_cycle();
    int winner;
    int wr_port;
    logic upd;
    logic exp_reject;
    logic write_ok;
    int wr_pri;
    int wr_data;
    winner = pick_winner();
    wr_port = int'(in_port);
    wr_pri = int'(in_pri);
    wr_data = int'(in_data);
    upd = update_en;
    exp_reject = in_valid && model_full[wr_port];
    write_ok = in_valid && !model_full[wr_port];
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    if (winner >= 0) begin
      model_full[winner] = 1'b0;
      if (upd) model_last = winner;
    end
    // The written slot was empty, so it is never the winner
    if (write_ok) begin
      model_full[wr_port] = 1'b1;
      model_pri[wr_port] = wr_pri;
      model_data[wr_port] = wr_data;
      accepted++;
    end
    check_value("out_valid", int'(winner >= 0), int'(out_valid));
    if (winner >= 0) begin
      check_value("out_port", winner, int'(out_port));
      check_value("out_pri", model_pri[winner], int'(out_pri));
      check_value("out_data", model_data[winner], int'(out_data));
    end
    if (out_valid) begin
      port_log.push_back(int'(out_port));
      pri_log.push_back(int'(out_pri));
      data_log.push_back(int'(out_data));
    end
    check_value("in_reject", int'(exp_reject), int'(in_reject));
    check_value("slot_full", int'(model_full), int'(slot_full));
  endtask

  task automatic send(int port, int pri, int data);
    in_valid = 1'b1;
    in_port = idx_w'(port);
    in_pri = pri_w'(pri);
    in_data = data_w'(data);
    clock_cycle();
  endtask

  // Slot flags drop once the last held command has been granted
  task automatic drain();
    while (slot_full != '0) clock_cycle();
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
    accepted = 0;
    port_log.delete();
    pri_log.delete();
    data_log.delete();
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d errors", test_name, test_errors);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  // With one input port a slot is written at most once per edge and a
  // held command is granted in the next cycle, so outputs follow the
  // issue order and the model confirms priority and pointer on top
  task automatic single_command();
    logic [data_w-1:0] data;
    start_test("single_command");
    check_value("out_valid after reset", 0, int'(out_valid));
    check_value("in_reject after reset", 0, int'(in_reject));
    check_value("slot_full after reset", 0, int'(slot_full));
    data = data_w'($urandom);
    update_en = 1'b1;
    send(2, 1, int'(data));
    // First edge is the write edge
    check_value("slot 2 full after write", 1, int'(slot_full[2]));
    check_value("out_valid after write edge", 0, int'(out_valid));
    clock_cycle();
    check_value("out_valid at second edge", 1, int'(out_valid));
    check_value("out_port at second edge", 2, int'(out_port));
    check_value("out_pri at second edge", 1, int'(out_pri));
    check_value("out_data at second edge", int'(data), int'(out_data));
    check_value("slot 2 full after grant", 0, int'(slot_full[2]));
    clock_cycle();
    check_value("out_valid pulse width", 0, int'(out_valid));
    end_test();
  endtask

  task automatic priority_order();
    int expected[$];
    start_test("priority_order");
    update_en = 1'b1;
    for (int p = num_pri - 1; p >= 0; p--) begin
      send(p, p, int'(data_w'($urandom)));
      expected.push_back(p);
    end
    drain();
    check_order("priority", expected, pri_log);
    end_test();
  endtask

  task automatic round_robin();
    int expected[$];
    start_test("round_robin");
    update_en = 1'b1;
    for (int k = 0; k <= num_req; k++) begin
      send(k % num_req, 2, int'(data_w'($urandom)));
      expected.push_back(k % num_req);
    end
    drain();
    check_order("grant", expected, port_log);
    end_test();
  endtask

  task automatic frozen_state();
    int expected[$];
    start_test("frozen_state");
    update_en = 1'b0;
    // Slot 0 is refilled once its grant edge has passed
    repeat (3) begin
      send(0, 1, int'(data_w'($urandom)));
      clock_cycle();
      expected.push_back(0);
    end
    update_en = 1'b1;
    for (int k = 1; k <= num_req; k++) begin
      send(k % num_req, 1, int'(data_w'($urandom)));
      expected.push_back(k % num_req);
    end
    drain();
    check_order("grant", expected, port_log);
    end_test();
  endtask

  task automatic reject_full();
    logic [data_w-1:0] first_data;
    start_test("reject_full");
    update_en = 1'b1;
    first_data = data_w'($urandom);
    send(1, 3, int'(first_data));
    // Slot 1 is granted at this edge but still counts as full
    send(1, 0, int'(~first_data));
    check_value("in_reject after full write", 1, int'(in_reject));
    check_value("out_valid with reject", 1, int'(out_valid));
    check_value("out_data kept", int'(first_data), int'(out_data));
    clock_cycle();
    check_value("in_reject pulse width", 0, int'(in_reject));
    check_value("out_valid after reject", 0, int'(out_valid));
    check_value("output count", 1, data_log.size());
    end_test();
  endtask

  task automatic random_mix();
    start_test("random_mix");
    repeat (random_cycles) begin
      in_valid = 1'($urandom);
      in_port = idx_w'($urandom);
      in_pri = pri_w'($urandom);
      in_data = data_w'($urandom);
      update_en = 1'($urandom);
      clock_cycle();
    end
    update_en = 1'b1;
    drain();
    // Every accepted command leaves exactly once
    check_value("outputs per accepted command", accepted, data_log.size());
    end_test();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(33838));
    reset = 1'b1;
    in_valid = 1'b0;
    in_port = '0;
    in_pri = '0;
    in_data = '0;
    update_en = 1'b0;
    model_full = '0;
    model_last = num_req - 1;
    accepted = 0;
    test_errors = 0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    single_command();
    priority_order();
    round_robin();
    frozen_state();
    reject_full();
    random_mix();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/arb_subsys.sv
// ------------------------------------------------------------
// Request arbitration subsystem top
// Dispatcher, one holding slot per requester and the
// arbitrated output port
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module arb_subsys (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  input  logic [arb_pkg::idx_w-1:0]   in_port,
  input  logic [arb_pkg::pri_w-1:0]   in_pri,
  input  logic [arb_pkg::data_w-1:0]  in_data,
  input  logic                        update_en,
  output logic                        in_reject,
  output logic [arb_pkg::num_req-1:0] slot_full,
  output logic                        out_valid,
  output logic [arb_pkg::idx_w-1:0]   out_port,
  output logic [arb_pkg::pri_w-1:0]   out_pri,
  output logic [arb_pkg::data_w-1:0]  out_data
);
  import arb_pkg::*;

  logic [num_req-1:0] wr_en;
  logic [pri_w-1:0] wr_pri;
  logic [data_w-1:0] wr_data;

  // One bundle per slot between the slots and the grant side
  req_if slot_if [num_req] ();

  req_dispatch req_dispatch_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_port   (in_port),
    .in_pri    (in_pri),
    .in_data   (in_data),
    .slot_full (slot_full),
    .wr_en     (wr_en),
    .wr_pri    (wr_pri),
    .wr_data   (wr_data),
    .in_reject (in_reject)
  );

  for (genvar i = 0; i < num_req; i++) begin : gen_slot
    req_slot req_slot_i (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (wr_en[i]),
      .wr_pri  (wr_pri),
      .wr_data (wr_data),
      .full    (slot_full[i]),
      .port    (slot_if[i])
    );
  end

  grant_mux grant_mux_i (
    .clk       (clk),
    .reset     (reset),
    .update_en (update_en),
    .slots     (slot_if),
    .out_valid (out_valid),
    .out_port  (out_port),
    .out_pri   (out_pri),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// File: hdl/grant_mux.sv
// ------------------------------------------------------------
// Grant multiplexer
// Arbitrates between the slots, clears the winner and
// registers its command onto the output port
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module grant_mux (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        update_en,
  req_if.drain                        slots [arb_pkg::num_req],
  output logic                        out_valid,
  output logic [arb_pkg::idx_w-1:0]   out_port,
  output logic [arb_pkg::pri_w-1:0]   out_pri,
  output logic [arb_pkg::data_w-1:0]  out_data
);
  import arb_pkg::*;

  logic [num_req-1:0] request;
  logic [num_req-1:0][pri_w-1:0] request_priority;
  logic [num_req-1:0][data_w-1:0] request_data;
  logic [num_req-1:0] grant;
  logic [idx_w-1:0] sel_idx;
  logic [pri_w-1:0] sel_pri;
  logic [data_w-1:0] sel_data;

  // Gather the slot bundles into vectors and hand back the grants
  for (genvar i = 0; i < num_req; i++) begin : gen_gather
    assign request[i]          = slots[i].request;
    assign request_priority[i] = slots[i].pri;
    assign request_data[i]     = slots[i].data;
    assign slots[i].grant      = grant[i];
  end

  arb_pri_rr arb_i (
    .clk              (clk),
    .reset            (reset),
    .update_en        (update_en),
    .request          (request),
    .request_priority (request_priority),
    .grant            (grant)
  );

  // Grant is one-hot, so the last match is the only match
  always_comb begin
    sel_idx  = '0;
    sel_pri  = '0;
    sel_data = '0;
    for (int i = 0; i < num_req; i++) begin
      if (grant[i]) begin
        sel_idx  = idx_w'(i);
        sel_pri  = request_priority[i];
        sel_data = request_data[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |grant;
    end
  end

  always_ff @(posedge clk) begin
    if (|grant) begin
      out_port <= sel_idx;
      out_pri  <= sel_pri;
      out_data <= sel_data;
    end
  end

  // Back-to-back outputs need a held command in the first cycle
  out_needs_slot_a: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !(|request)) |=> !out_valid);

endmodule

`default_nettype wire

// File: hdl/req_dispatch.sv
// ------------------------------------------------------------
// Command dispatcher
// Steers incoming commands to free slots and flags those
// that address an occupied slot
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module req_dispatch (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  input  logic [arb_pkg::idx_w-1:0]   in_port,
  input  logic [arb_pkg::pri_w-1:0]   in_pri,
  input  logic [arb_pkg::data_w-1:0]  in_data,
  input  logic [arb_pkg::num_req-1:0] slot_full,
  output logic [arb_pkg::num_req-1:0] wr_en,
  output logic [arb_pkg::pri_w-1:0]   wr_pri,
  output logic [arb_pkg::data_w-1:0]  wr_data,
  output logic                        in_reject
);
  import arb_pkg::*;

  // One strobe for the addressed slot, and only when it is empty.
  // A slot granted this cycle is still full here
  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      wr_en[i] = in_valid && (in_port == idx_w'(i)) && !slot_full[i];
    end
  end

  // Every slot sees the same payload, the strobe picks the target
  assign wr_pri  = in_pri;
  assign wr_data = in_data;

  // Reject pulses in the cycle after the dropped command
  always_ff @(posedge clk) begin
    if (reset) begin
      in_reject <= 1'b0;
    end else begin
      in_reject <= in_valid && slot_full[in_port];
    end
  end

endmodule

`default_nettype wire

// File: hdl/req_slot.sv
// ------------------------------------------------------------
// Request holding slot
// Holds one command and its priority until the arbiter
// grants it
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module req_slot (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        wr_en,
  input  logic [arb_pkg::pri_w-1:0]   wr_pri,
  input  logic [arb_pkg::data_w-1:0]  wr_data,
  output logic                        full,
  req_if.slot                         port
);
  import arb_pkg::*;

  logic valid;
  logic [pri_w-1:0] pri_q;
  logic [data_w-1:0] data_q;

  // A write only reaches an empty slot and a grant only a full one,
  // so the two never meet in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (wr_en) begin
      valid <= 1'b1;
    end else if (port.grant) begin
      valid <= 1'b0;
    end
  end

  // Payload follows the write strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      pri_q  <= wr_pri;
      data_q <= wr_data;
    end
  end

  assign full         = valid;
  assign port.request = valid;
  assign port.pri     = pri_q;
  assign port.data    = data_q;

  // The dispatcher must reject commands aimed at an occupied slot
  no_overwrite_a: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !valid);

endmodule

`default_nettype wire

// File: hdl/arb_pri_rr.sv
// ------------------------------------------------------------
// Prioritized round-robin arbiter
// Grants one request per cycle with zero latency. The highest
// priority wins and round-robin state breaks ties
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module arb_pri_rr (
  input  logic                                             clk,
  input  logic                                             reset,
  input  logic                                             update_en,
  input  logic [arb_pkg::num_req-1:0]                      request,
  input  logic [arb_pkg::num_req-1:0][arb_pkg::pri_w-1:0]  request_priority,
  output logic [arb_pkg::num_req-1:0]                      grant
);
  import arb_pkg::*;

  localparam int flat_w = (num_pri + 1) * num_req;

  logic update;
  logic [num_req-1:0] priority_mask;
  logic [num_pri:0][num_req-1:0] request_unrolled;
  logic [flat_w-1:0] request_flat;
  logic [flat_w-1:0] any_higher;
  logic [num_pri:0][num_req-1:0] grant_unrolled;

  // ------------------------------------------------------------
  // Round-robin state
  // ------------------------------------------------------------

  // The pointer only moves when a grant is actually made
  assign update = update_en && |request;

  rr_state rr_state_i (
    .clk           (clk),
    .reset         (reset),
    .update        (update),
    .grant         (grant),
    .priority_mask (priority_mask)
  );

  // ------------------------------------------------------------
  // Unroll priorities into thermometer levels
  // ------------------------------------------------------------

  // Level p holds requests with priority at least num_pri-1-p that are
  // not masked, plus masked requests one priority step higher.
  // Level 0 is the most urgent, the last level is every request
  always_comb begin
    for (int p = 0; p < num_pri; p++) begin
      for (int i = 0; i < num_req; i++) begin
        request_unrolled[p][i] = request[i] && (
          ((int'(request_priority[i]) >= num_pri - 1 - p) && !priority_mask[i]) ||
          ((p > 0) && (int'(request_priority[i]) >= num_pri - p) && priority_mask[i]));
      end
    end
    request_unrolled[num_pri] = request;
  end

  // ------------------------------------------------------------
  // Flattened fixed-priority search
  // ------------------------------------------------------------

  assign request_flat = request_unrolled;

  // Bit 0 of the flat vector has the highest priority
  always_comb begin
    any_higher[0] = 1'b0;
    for (int i = 1; i < flat_w; i++) begin
      any_higher[i] = any_higher[i-1] | request_flat[i-1];
    end
  end

  assign grant_unrolled = request_flat & ~any_higher;

  // At most one level bit survives, so the OR is still one-hot
  always_comb begin
    grant = '0;
    for (int p = 0; p <= num_pri; p++) begin
      grant |= grant_unrolled[p];
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  grant_onehot_a: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant));
  always_grant_a: assert property (@(posedge clk) disable iff (reset)
    |request |-> |grant);
  grant_in_request_a: assert property (@(posedge clk) disable iff (reset)
    (grant & ~request) == '0);

endmodule

`default_nettype wire

// File: hdl/rr_state.sv
// ------------------------------------------------------------
// Round-robin state
// Remembers the last granted index and presents it as a
// thermometer mask of lower round-robin priority
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rr_state (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         update,
  input  logic [arb_pkg::num_req-1:0]  grant,
  output logic [arb_pkg::num_req-1:0]  priority_mask
);
  import arb_pkg::*;

  logic have_grant;
  logic [idx_w-1:0] last_idx;
  logic [idx_w-1:0] grant_idx;

  // Encode the one-hot grant into an index
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < num_req; i++) begin
      if (grant[i]) grant_idx = idx_w'(i);
    end
  end

  // Until the first grant nothing is masked, so index 0 goes first
  always_ff @(posedge clk) begin
    if (reset) begin
      have_grant <= 1'b0;
      last_idx   <= '0;
    end else if (update) begin
      have_grant <= 1'b1;
      last_idx   <= grant_idx;
    end
  end

  // Indices up to and including the last grant drop behind the others
  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      priority_mask[i] = have_grant && (idx_w'(i) <= last_idx);
    end
  end

  // The encoder above only holds for a single grant bit
  update_onehot_a: assert property (@(posedge clk) disable iff (reset)
    update |-> $onehot0(grant));

endmodule

`default_nettype wire

// File: hdl/req_if.sv
// ------------------------------------------------------------
// Slot request bundle
// Carries one slot's held command towards the arbiter and
// the grant strobe back to the slot
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface req_if;
  import arb_pkg::*;

  // High while the slot holds a command
  logic request;
  logic [pri_w-1:0] pri;
  logic [data_w-1:0] data;
  // One-cycle strobe, the slot empties at the next edge
  logic grant;

  // Slot side owns the command, drain side owns the grant
  modport slot (output request, output pri, output data, input grant);
  modport drain (input request, input pri, input data, output grant);

endinterface

`default_nettype wire

// File: hdl/arb_pkg.sv
// ------------------------------------------------------------
// Arbitration subsystem shared sizes
// Requester count, priority levels and the widths derived
// from them, used by every block of the subsystem
// ------------------------------------------------------------

`default_nettype none

package arb_pkg;

  // ------------------------------------------------------------
  // Requesters and priorities
  // ------------------------------------------------------------

  // Number of requesters, one holding slot each
  localparam int num_req = 4;

  // Priority levels, 0 is the lowest and num_pri-1 the highest
  localparam int num_pri = 4;

  // ------------------------------------------------------------
  // Derived widths
  // ------------------------------------------------------------

  localparam int pri_w = $clog2(num_pri);
  localparam int data_w = 16;

  // Width of a requester index on the input and output ports
  localparam int idx_w = $clog2(num_req);

endpackage

`default_nettype wire
